/* Makefile */
# Verilator build and run of the ant position updater testbench

VERILATOR ?= verilator
TOP       ?= tb_ant_update
FILELIST  ?= ant_update.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* ant_update.f */
source/ant_pkg.sv
source/ant_update_ctrl.sv
source/food_stage.sv
source/ant_mover.sv
source/ant_update_top.sv
tests/tb_clock.sv
tests/tb_memory.sv
tests/tb_checker.sv
tests/tb_ant_update.sv

/* source/ant_mover.sv */
`timescale 1ns/1ps

module ant_mover
    import ant_pkg::*;
(
    input  logic   clock,
    input  logic   resetn,

    // closest food out of the stage chain
    input  logic   best_valid,
    input  coord_t best_x,
    input  coord_t best_y,

    // current ant position
    input  coord_t ant_x,
    input  coord_t ant_y,

    output logic   move_done,
    output coord_t new_x,
    output coord_t new_y
);

    coord_t step_x;
    coord_t step_y;

    // one pixel toward the target but never past the margins
    function automatic coord_t step_axis(
        input coord_t pos,
        input coord_t target,
        input coord_t lo,
        input coord_t hi
    );
        coord_t next;
        next = pos;
        if ((target > pos) && (pos < hi)) begin
            next = pos + 1'b1;
        end else if ((target < pos) && (pos > lo)) begin
            next = pos - 1'b1;
        end
        return next;
    endfunction

    always_comb begin
        step_x = step_axis(ant_x, best_x, X_MIN, X_MAX);
        step_y = step_axis(ant_y, best_y, Y_MIN, Y_MAX);
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            move_done <= 1'b0;
        end else begin
            move_done <= best_valid;
        end
    end

    // result holds until the next sweep so the write-back can read it later
    always_ff @(posedge clock) begin
        if (best_valid) begin
            new_x <= step_x;
            new_y <= step_y;
        end
    end

endmodule

/* source/ant_pkg.sv */
package ant_pkg;

    // data widths
    localparam int COORD_WIDTH      = 8;
    localparam int DIST_WIDTH       = 9;
    localparam int NUM_FOOD         = 8;
    localparam int FOOD_INDEX_WIDTH = 3;
    localparam int ANT_ID_WIDTH     = 4;
    localparam int MEM_ADDR_WIDTH   = 8;

    typedef logic [COORD_WIDTH-1:0]      coord_t;
    typedef logic [DIST_WIDTH-1:0]       dist_t;
    typedef logic [FOOD_INDEX_WIDTH-1:0] food_index_t;
    typedef logic [ANT_ID_WIDTH-1:0]     ant_id_t;
    typedef logic [MEM_ADDR_WIDTH-1:0]   mem_addr_t;

    // screen and sprite geometry
    localparam int SCREEN_WIDTH  = 160;
    localparam int SCREEN_HEIGHT = 120;
    localparam int ANT_WIDTH     = 4;
    localparam int ANT_HEIGHT    = 4;

    // the ant centre stays half a sprite away from every edge
    localparam coord_t X_MIN = coord_t'(ANT_WIDTH / 2);
    localparam coord_t X_MAX = coord_t'(SCREEN_WIDTH - ANT_WIDTH / 2 - 1);
    localparam coord_t Y_MIN = coord_t'(ANT_HEIGHT / 2);
    localparam coord_t Y_MAX = coord_t'(SCREEN_HEIGHT - ANT_HEIGHT / 2 - 1);

    // word memory map with each entry at its base plus index
    localparam mem_addr_t ANT_X_BASE  = mem_addr_t'(0);
    localparam mem_addr_t ANT_Y_BASE  = mem_addr_t'(16);
    localparam mem_addr_t FOOD_X_BASE = mem_addr_t'(32);
    localparam mem_addr_t FOOD_Y_BASE = mem_addr_t'(40);

    // update controller states
    typedef enum logic [3:0] {
        IDLE,
        READ_ANT_X,
        READ_ANT_Y,
        READ_FOOD_X,
        READ_FOOD_Y,
        SWEEP,
        WRITE_X,
        WRITE_Y,
        DONE
    } ctrl_state_t;

endpackage

/* source/ant_update_ctrl.sv */
`timescale 1ns/1ps

module ant_update_ctrl
    import ant_pkg::*;
(
    input  logic        clock,
    input  logic        resetn,

    // host side
    input  logic        req,
    input  ant_id_t     ant_id,
    output logic        ack,

    // word memory side
    output logic        mem_req,
    output logic        mem_write,
    output mem_addr_t   mem_addr,
    output coord_t      mem_wdata,
    input  logic        mem_ack,
    input  coord_t      mem_rdata,

    // food stage loading and sweep
    output logic        load_valid,
    output food_index_t load_index,
    output coord_t      load_x,
    output coord_t      load_y,
    output coord_t      ant_x,
    output coord_t      ant_y,
    output logic        sweep_start,

    // result from the mover
    input  logic        move_done,
    input  coord_t      new_x,
    input  coord_t      new_y
);

    ctrl_state_t state;
    ant_id_t     id_q;
    food_index_t food_index;
    coord_t      food_x_hold;

    logic mem_start;
    logic mem_done;
    logic last_food;

    // a new access opens only once the previous one has fully closed
    assign mem_start = !mem_req && !mem_ack;
    assign mem_done  = mem_req && mem_ack;
    assign last_food = (food_index == food_index_t'(NUM_FOOD - 1));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state       <= IDLE;
            ack         <= 1'b0;
            mem_req     <= 1'b0;
            mem_write   <= 1'b0;
            load_valid  <= 1'b0;
            sweep_start <= 1'b0;
            food_index  <= '0;
        end else begin
            load_valid <= 1'b0;
            // sweep begins the cycle after the last entry is broadcast
            sweep_start <= load_valid && (load_index == food_index_t'(NUM_FOOD - 1));

            case (state)
                IDLE: begin
                    if (req) begin
                        id_q       <= ant_id;
                        food_index <= '0;
                        state      <= READ_ANT_X;
                    end
                end

                READ_ANT_X: begin
                    if (mem_start) begin
                        mem_req   <= 1'b1;
                        mem_write <= 1'b0;
                        mem_addr  <= ANT_X_BASE + mem_addr_t'(id_q);
                    end
                    if (mem_done) begin
                        mem_req <= 1'b0;
                        ant_x   <= mem_rdata;
                        state   <= READ_ANT_Y;
                    end
                end

                READ_ANT_Y: begin
                    if (mem_start) begin
                        mem_req   <= 1'b1;
                        mem_write <= 1'b0;
                        mem_addr  <= ANT_Y_BASE + mem_addr_t'(id_q);
                    end
                    if (mem_done) begin
                        mem_req <= 1'b0;
                        ant_y   <= mem_rdata;
                        state   <= READ_FOOD_X;
                    end
                end

                READ_FOOD_X: begin
                    if (mem_start) begin
                        mem_req   <= 1'b1;
                        mem_write <= 1'b0;
                        mem_addr  <= FOOD_X_BASE + mem_addr_t'(food_index);
                    end
                    if (mem_done) begin
                        mem_req     <= 1'b0;
                        // kept until the matching y comes back
                        food_x_hold <= mem_rdata;
                        state       <= READ_FOOD_Y;
                    end
                end

                READ_FOOD_Y: begin
                    if (mem_start) begin
                        mem_req   <= 1'b1;
                        mem_write <= 1'b0;
                        mem_addr  <= FOOD_Y_BASE + mem_addr_t'(food_index);
                    end
                    if (mem_done) begin
                        mem_req    <= 1'b0;
                        load_valid <= 1'b1;
                        load_index <= food_index;
                        load_x     <= food_x_hold;
                        load_y     <= mem_rdata;
                        if (last_food) begin
                            food_index <= '0;
                            state      <= SWEEP;
                        end else begin
                            food_index <= food_index + 1'b1;
                            state      <= READ_FOOD_X;
                        end
                    end
                end

                SWEEP: begin
                    if (move_done) begin
                        state <= WRITE_X;
                    end
                end

                WRITE_X: begin
                    if (mem_start) begin
                        mem_req   <= 1'b1;
                        mem_write <= 1'b1;
                        mem_addr  <= ANT_X_BASE + mem_addr_t'(id_q);
                        mem_wdata <= new_x;
                    end
                    if (mem_done) begin
                        mem_req <= 1'b0;
                        state   <= WRITE_Y;
                    end
                end

                WRITE_Y: begin
                    if (mem_start) begin
                        mem_req   <= 1'b1;
                        mem_write <= 1'b1;
                        mem_addr  <= ANT_Y_BASE + mem_addr_t'(id_q);
                        mem_wdata <= new_y;
                    end
                    if (mem_done) begin
                        mem_req   <= 1'b0;
                        mem_write <= 1'b0;
                        ack       <= 1'b1;
                        state     <= DONE;
                    end
                end

                DONE: begin
                    // ack falls only after the host lets go of req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* source/ant_update_top.sv */
`timescale 1ns/1ps

module ant_update_top
    import ant_pkg::*;
(
    input  logic      clock,
    input  logic      resetn,
    input  logic      req,
    input  ant_id_t   ant_id,
    output logic      ack,
    output logic      mem_req,
    output logic      mem_write,
    output mem_addr_t mem_addr,
    output coord_t    mem_wdata,
    input  logic      mem_ack,
    input  coord_t    mem_rdata
);

    logic        load_valid;
    food_index_t load_index;
    coord_t      load_x;
    coord_t      load_y;
    coord_t      ant_x;
    coord_t      ant_y;
    logic        sweep_start;
    logic        move_done;
    coord_t      new_x;
    coord_t      new_y;

    // best-so-far chain where slot 0 feeds stage 0 and the last slot feeds the mover
    logic   chain_valid [0:NUM_FOOD];
    dist_t  chain_dist  [0:NUM_FOOD];
    coord_t chain_x     [0:NUM_FOOD];
    coord_t chain_y     [0:NUM_FOOD];

    // all ones lies beyond any real distance and stands for no best yet
    assign chain_valid[0] = sweep_start;
    assign chain_dist[0]  = '1;
    assign chain_x[0]     = '0;
    assign chain_y[0]     = '0;

    ant_update_ctrl u_ctrl (
        .clock       (clock),
        .resetn      (resetn),
        .req         (req),
        .ant_id      (ant_id),
        .ack         (ack),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .load_valid  (load_valid),
        .load_index  (load_index),
        .load_x      (load_x),
        .load_y      (load_y),
        .ant_x       (ant_x),
        .ant_y       (ant_y),
        .sweep_start (sweep_start),
        .move_done   (move_done),
        .new_x       (new_x),
        .new_y       (new_y)
    );

    for (genvar i = 0; i < NUM_FOOD; i++) begin : g_stage
        food_stage #(
            .STAGE_INDEX (i)
        ) u_stage (
            .clock      (clock),
            .resetn     (resetn),
            .load_valid (load_valid),
            .load_index (load_index),
            .load_x     (load_x),
            .load_y     (load_y),
            .ant_x      (ant_x),
            .ant_y      (ant_y),
            .in_valid   (chain_valid[i]),
            .in_dist    (chain_dist[i]),
            .in_x       (chain_x[i]),
            .in_y       (chain_y[i]),
            .out_valid  (chain_valid[i+1]),
            .out_dist   (chain_dist[i+1]),
            .out_x      (chain_x[i+1]),
            .out_y      (chain_y[i+1])
        );
    end

    ant_mover u_mover (
        .clock      (clock),
        .resetn     (resetn),
        .best_valid (chain_valid[NUM_FOOD]),
        .best_x     (chain_x[NUM_FOOD]),
        .best_y     (chain_y[NUM_FOOD]),
        .ant_x      (ant_x),
        .ant_y      (ant_y),
        .move_done  (move_done),
        .new_x      (new_x),
        .new_y      (new_y)
    );

endmodule

/* source/food_stage.sv */
`timescale 1ns/1ps

module food_stage
    import ant_pkg::*;
#(
    parameter int STAGE_INDEX = 0
) (
    input  logic        clock,
    input  logic        resetn,

    // entry load broadcast
    input  logic        load_valid,
    input  food_index_t load_index,
    input  coord_t      load_x,
    input  coord_t      load_y,
    input  coord_t      ant_x,
    input  coord_t      ant_y,

    // best so far from the previous stage
    input  logic        in_valid,
    input  dist_t       in_dist,
    input  coord_t      in_x,
    input  coord_t      in_y,

    // best so far to the next stage
    output logic        out_valid,
    output dist_t       out_dist,
    output coord_t      out_x,
    output coord_t      out_y
);

    coord_t food_x;
    coord_t food_y;
    coord_t diff_x;
    coord_t diff_y;
    dist_t  own_dist;
    logic   take_own;

    always_ff @(posedge clock) begin
        if (load_valid && (load_index == food_index_t'(STAGE_INDEX))) begin
            food_x <= load_x;
            food_y <= load_y;
        end
    end

    // manhattan distance to the ant
    always_comb begin
        diff_x   = (food_x > ant_x) ? food_x - ant_x : ant_x - food_x;
        diff_y   = (food_y > ant_y) ? food_y - ant_y : ant_y - food_y;
        own_dist = dist_t'(diff_x) + dist_t'(diff_y);
        // strictly smaller only, so on a tie the earlier stage keeps the lead
        take_own = (own_dist < in_dist);
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_dist <= take_own ? own_dist : in_dist;
            out_x    <= take_own ? food_x : in_x;
            out_y    <= take_own ? food_y : in_y;
        end
    end

endmodule

/* tests/tb_ant_update.sv */
`timescale 1ns/1ps

module tb_ant_update
    import ant_pkg::*;
();

    localparam int          CLOCK_PERIOD  = 20;
    localparam int          RESET_CYCLES  = 5;
    localparam int          DRIVE_DELAY   = 2;
    localparam logic [31:0] SEED          = 32'hc7bb;
    localparam int          NUM_ROWS      = 8;
    localparam int          UPDATE_CYCLES = 200;
    localparam int          FOOD_BITS     = COORD_WIDTH * NUM_FOOD;

    logic      clock;
    logic      resetn;
    logic      req;
    ant_id_t   ant_id;
    logic      ack;
    logic      mem_req;
    logic      mem_write;
    mem_addr_t mem_addr;
    coord_t    mem_wdata;
    logic      mem_ack;
    coord_t    mem_rdata;

    // stimulus table with food 0 in the top byte of each food vector
    string                row_name   [NUM_ROWS];
    ant_id_t              row_id     [NUM_ROWS];
    coord_t               row_ant_x  [NUM_ROWS];
    coord_t               row_ant_y  [NUM_ROWS];
    logic [FOOD_BITS-1:0] row_food_x [NUM_ROWS];
    logic [FOOD_BITS-1:0] row_food_y [NUM_ROWS];
    coord_t               row_exp_x  [NUM_ROWS];
    coord_t               row_exp_y  [NUM_ROWS];
    int                   row_count = 0;

    tb_clock #(
        .PERIOD_NS    (CLOCK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES),
        .DRIVE_DELAY  (DRIVE_DELAY)
    ) clk0 (
        .clock  (clock),
        .resetn (resetn)
    );

    ant_update_top dut0 (
        .clock     (clock),
        .resetn    (resetn),
        .req       (req),
        .ant_id    (ant_id),
        .ack       (ack),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    tb_memory #(
        .SEED (SEED)
    ) mem0 (
        .clock     (clock),
        .resetn    (resetn),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    tb_checker chk0 (
        .clock     (clock),
        .resetn    (resetn),
        .req       (req),
        .ack       (ack),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack)
    );

    task automatic add_row(input string name, input int id, input int ax, input int ay,
                           input logic [FOOD_BITS-1:0] fx, input logic [FOOD_BITS-1:0] fy,
                           input int ex, input int ey);
        row_name[row_count]   = name;
        row_id[row_count]     = ant_id_t'(id);
        row_ant_x[row_count]  = coord_t'(ax);
        row_ant_y[row_count]  = coord_t'(ay);
        row_food_x[row_count] = fx;
        row_food_y[row_count] = fy;
        row_exp_x[row_count]  = coord_t'(ex);
        row_exp_y[row_count]  = coord_t'(ey);
        row_count++;
    endtask

    // starts and ends a little after a rising edge
    task automatic run_row(input int r);
        int k;
        mem0.load_word(ANT_X_BASE + mem_addr_t'(row_id[r]), row_ant_x[r]);
        mem0.load_word(ANT_Y_BASE + mem_addr_t'(row_id[r]), row_ant_y[r]);
        for (k = 0; k < NUM_FOOD; k++) begin
            mem0.load_word(FOOD_X_BASE + mem_addr_t'(k),
                           row_food_x[r][FOOD_BITS - COORD_WIDTH * (k + 1) +: COORD_WIDTH]);
            mem0.load_word(FOOD_Y_BASE + mem_addr_t'(k),
                           row_food_y[r][FOOD_BITS - COORD_WIDTH * (k + 1) +: COORD_WIDTH]);
        end
        chk0.start_test(row_name[r], row_id[r], row_exp_x[r], row_exp_y[r]);
        ant_id = row_id[r];
        req    = 1'b1;
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
        end while (!ack);
        // keep req up a little longer so ack has to wait for it
        repeat (1 + r % 3) @(posedge clock);
        #DRIVE_DELAY;
        req = 1'b0;
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
        end while (ack);
        @(posedge clock);
        #DRIVE_DELAY;
        chk0.finish_test();
    endtask

    initial begin : main
        int r;
        req    = 1'b0;
        ant_id = '0;
        add_row("closest_diagonal", 3, 50, 60,
                {8'd100, 8'd55, 8'd20, 8'd150, 8'd60, 8'd10, 8'd80, 8'd45},
                {8'd100, 8'd64, 8'd20, 8'd10, 8'd70, 8'd110, 8'd30, 8'd50}, 51, 61);
        add_row("closest_last", 7, 100, 40,
                {8'd10, 8'd150, 8'd90, 8'd130, 8'd5, 8'd140, 8'd60, 8'd97},
                {8'd10, 8'd110, 8'd90, 8'd20, 8'd115, 8'd80, 8'd10, 8'd43}, 99, 41);
        add_row("tie_lower_index", 1, 80, 60,
                {8'd10, 8'd150, 8'd70, 8'd20, 8'd140, 8'd90, 8'd5, 8'd155},
                {8'd10, 8'd110, 8'd60, 8'd100, 8'd20, 8'd60, 8'd115, 8'd5}, 79, 60);
        add_row("x_axis_equal", 0, 40, 40,
                {8'd100, 8'd10, 8'd150, 8'd40, 8'd70, 8'd40, 8'd2, 8'd120},
                {8'd100, 8'd90, 8'd5, 8'd45, 8'd40, 8'd90, 8'd2, 8'd60}, 40, 41);
        add_row("held_at_x_max", 12, 157, 30,
                {8'd159, 8'd10, 8'd100, 8'd60, 8'd20, 8'd130, 8'd80, 8'd140},
                {8'd20, 8'd10, 8'd100, 8'd60, 8'd110, 8'd90, 8'd5, 8'd70}, 157, 29);
        add_row("held_at_y_max", 15, 20, 117,
                {8'd100, 8'd150, 8'd60, 8'd5, 8'd25, 8'd90, 8'd140, 8'd40},
                {8'd10, 8'd60, 8'd60, 8'd5, 8'd119, 8'd100, 8'd20, 8'd80}, 21, 117);
        add_row("held_at_min", 9, 2, 2,
                {8'd100, 8'd50, 8'd10, 8'd150, 8'd80, 8'd30, 8'd0, 8'd2},
                {8'd100, 8'd5, 8'd60, 8'd110, 8'd30, 8'd2, 8'd1, 8'd20}, 2, 2);
        add_row("mixed_directions", 5, 120, 90,
                {8'd10, 8'd125, 8'd30, 8'd110, 8'd150, 8'd60, 8'd5, 8'd121},
                {8'd10, 8'd80, 8'd50, 8'd100, 8'd5, 8'd110, 8'd115, 8'd89}, 121, 89);

        @(posedge resetn);
        // a few idle cycles so the quiet state after reset gets watched
        repeat (3) @(posedge clock);
        #DRIVE_DELAY;
        for (r = 0; r < row_count; r++) begin
            run_row(r);
        end
        repeat (2) @(posedge clock);
        chk0.report();
        if (chk0.all_clean(NUM_ROWS)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        #((RESET_CYCLES + 10 + NUM_ROWS * UPDATE_CYCLES) * CLOCK_PERIOD);
        $display("timeout: the updates did not finish within %0d cycles each",
                 UPDATE_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
    import ant_pkg::*;
(
    input logic      clock,
    input logic      resetn,
    input logic      req,
    input logic      ack,
    input logic      mem_req,
    input logic      mem_write,
    input mem_addr_t mem_addr,
    input coord_t    mem_wdata,
    input logic      mem_ack
);

    // ant x, ant y, every food x and y, then the two write-backs
    localparam int ACCESSES  = 2 + 2 * NUM_FOOD + 2;
    localparam int LOG_DEPTH = 1024;

    mem_addr_t log_addr  [0:LOG_DEPTH-1];
    logic      log_write [0:LOG_DEPTH-1];
    coord_t    log_data  [0:LOG_DEPTH-1];
    int        access_count;
    int        proto_errors;
    logic      seen_req;
    logic      req_q, ack_q, mem_req_q, mem_ack_q;
    mem_addr_t addr_q;

    // state of the test in progress
    string   cur_name;
    ant_id_t cur_id;
    coord_t  cur_x;
    coord_t  cur_y;
    int      cur_start;
    int      cur_proto;
    int      run_count  = 0;
    int      pass_count = 0;
    int      fail_count = 0;

    always @(posedge clock) begin : monitor
        int errs;
        errs = 0;
        if (!resetn) begin
            access_count <= 0;
            proto_errors <= 0;
            seen_req     <= 1'b0;
            req_q        <= 1'b0;
            ack_q        <= 1'b0;
            mem_req_q    <= 1'b0;
            mem_ack_q    <= 1'b0;
        end else begin
            if (!seen_req && !req && (ack || mem_req)) begin
                $display("ack or memory request came up before the first host request");
                errs++;
            end
            if (mem_req && !mem_req_q) begin
                if (mem_ack) begin
                    $display("memory request raised while the memory ack was still high");
                    errs++;
                end
                log_addr[access_count % LOG_DEPTH]  <= mem_addr;
                log_write[access_count % LOG_DEPTH] <= mem_write;
                log_data[access_count % LOG_DEPTH]  <= mem_wdata;
                access_count <= access_count + 1;
            end
            if (mem_req_q && !mem_req && !mem_ack_q) begin
                $display("memory request dropped before its ack came");
                errs++;
            end
            if (mem_req_q && mem_req && (mem_addr != addr_q)) begin
                $display("memory address changed in the middle of an access");
                errs++;
            end
            if (ack && !ack_q && !req) begin
                $display("host ack raised without a request");
                errs++;
            end
            if (ack_q && !ack && req_q) begin
                $display("host ack dropped while req was still high");
                errs++;
            end
            if (req) begin
                seen_req <= 1'b1;
            end
            req_q        <= req;
            ack_q        <= ack;
            mem_req_q    <= mem_req;
            mem_ack_q    <= mem_ack;
            addr_q       <= mem_addr;
            proto_errors <= proto_errors + errs;
        end
    end

    function automatic mem_addr_t expected_addr(input int i, input ant_id_t id);
        if ((i == 0) || (i == ACCESSES - 2)) begin
            return ANT_X_BASE + mem_addr_t'(id);
        end
        if ((i == 1) || (i == ACCESSES - 1)) begin
            return ANT_Y_BASE + mem_addr_t'(id);
        end
        if ((i % 2) == 0) begin
            return FOOD_X_BASE + mem_addr_t'((i - 2) / 2);
        end
        return FOOD_Y_BASE + mem_addr_t'((i - 2) / 2);
    endfunction

    task automatic start_test(input string name, input ant_id_t id,
                              input coord_t exp_x, input coord_t exp_y);
        cur_name  = name;
        cur_id    = id;
        cur_x     = exp_x;
        cur_y     = exp_y;
        cur_start = access_count;
        cur_proto = proto_errors;
    endtask

    task automatic finish_test();
        int        errs;
        int        seen;
        int        i;
        int        slot;
        mem_addr_t exp_addr;
        errs = 0;
        seen = access_count - cur_start;
        if (seen != ACCESSES) begin
            $display("%s: %0d memory accesses where %0d were due", cur_name, seen, ACCESSES);
            errs++;
        end else begin
            for (i = 0; i < ACCESSES; i++) begin
                slot     = (cur_start + i) % LOG_DEPTH;
                exp_addr = expected_addr(i, cur_id);
                if (log_addr[slot] != exp_addr) begin
                    $display("** Error %s: access %0d address expected %0d actual %0d",
                             cur_name, i, exp_addr, log_addr[slot]);
                    errs++;
                end
                if (log_write[slot] != (i >= ACCESSES - 2)) begin
                    $display("%s: access %0d went in the wrong direction", cur_name, i);
                    errs++;
                end
            end
            slot = (cur_start + ACCESSES - 2) % LOG_DEPTH;
            if (log_data[slot] != cur_x) begin
                $display("** Error %s: new x expected %0d actual %0d",
                         cur_name, cur_x, log_data[slot]);
                errs++;
            end
            slot = (cur_start + ACCESSES - 1) % LOG_DEPTH;
            if (log_data[slot] != cur_y) begin
                $display("** Error %s: new y expected %0d actual %0d",
                         cur_name, cur_y, log_data[slot]);
                errs++;
            end
        end
        if (proto_errors != cur_proto) begin
            $display("%s: handshake rules were broken during the update", cur_name);
            errs++;
        end
        run_count++;
        if (errs == 0) begin
            pass_count++;
            $display("test %s passed", cur_name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", cur_name, errs);
        end
    endtask

    task automatic report();
        $display("tests run %0d, passed %0d, failed %0d, handshake errors %0d",
                 run_count, pass_count, fail_count, proto_errors);
    endtask

    function automatic bit all_clean(input int expected_runs);
        return (fail_count == 0) && (proto_errors == 0) && (run_count == expected_runs);
    endfunction

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5,
    parameter int DRIVE_DELAY  = 2
) (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // reset released just after an edge in step with the other inputs
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        resetn = 1'b1;
    end

endmodule

/* tests/tb_memory.sv */
`timescale 1ns/1ps

module tb_memory
    import ant_pkg::*;
#(
    parameter logic [31:0] SEED      = 32'h1,
    parameter int          MAX_DELAY = 5
) (
    input  logic      clock,
    input  logic      resetn,
    input  logic      mem_req,
    input  logic      mem_write,
    input  mem_addr_t mem_addr,
    output logic      mem_ack,
    output coord_t    mem_rdata
);

    coord_t words [0:(1 << MEM_ADDR_WIDTH) - 1];
    logic   ack_r   = 1'b0;
    coord_t rdata_r = '0;
    logic   busy    = 1'b0;
    logic   seeded  = 1'b0;
    int     wait_count;

    assign mem_ack   = ack_r;
    assign mem_rdata = rdata_r;

    // preload from the testbench top while the DUT is idle
    task automatic load_word(input mem_addr_t addr, input coord_t value);
        words[addr] = value;
    endtask

    always @(posedge clock) begin
        if (!seeded) begin
            void'($urandom(SEED));
            seeded = 1'b1;
        end
        if (!resetn) begin
            ack_r      <= 1'b0;
            rdata_r    <= '0;
            busy       <= 1'b0;
            wait_count <= 0;
        end else if (mem_req && !ack_r) begin
            if (!busy) begin
                // random back-pressure before the answer
                busy       <= 1'b1;
                wait_count <= int'($urandom % (MAX_DELAY + 1));
            end else if (wait_count == 0) begin
                busy  <= 1'b0;
                ack_r <= 1'b1;
                // writes are only acknowledged
                if (!mem_write) begin
                    rdata_r <= words[mem_addr];
                end
            end else begin
                wait_count <= wait_count - 1;
            end
        end else if (!mem_req && ack_r) begin
            ack_r <= 1'b0;
        end
    end

endmodule
